// File: build.f
+incdir+include
verilog/mul_pkg.sv
verilog/lane_if.sv
verilog/cr_adder.sv
verilog/mul8_lane.sv
verilog/mul16_operand_split.sv
verilog/mul16_partial_sum.sv
verilog/mul16_top.sv
tb/mul16_properties.sv
tb/mul16_tb.sv

// File: include/mul_consts.svh
// widths fixed for an unsigned 16x16 multiply split into four 8x8 lanes; latency is in clock edges

`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// ----------------------------------------
// operand sizing
// ----------------------------------------

// full operand width, unsigned
`define MUL_OP_W    16
// byte width seen by one lane
`define MUL_HALF_W  8

// ----------------------------------------
// pipeline shape
// ----------------------------------------

// partial-product lanes, one per byte pair
`define MUL_LANES   4
// edges from sampled valid_i to valid_o
`define MUL_LATENCY 3

`endif

// File: tb/mul16_properties.sv
// bound into mul16_top; latency check is held off until the pipeline has cleared after reset

`default_nettype none

`include "mul_consts.svh"

module mul16_properties (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               valid_i,
  input  logic               valid_o,
  input  mul_pkg::product_t  prod_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import mul_pkg::*;

  // edges seen since reset release, saturates at the latency
  int unsigned settle_cnt;

  // ----------------------------------------
  // settle counter
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      settle_cnt <= 0;
    end else if (settle_cnt < `MUL_LATENCY) begin
      settle_cnt <= settle_cnt + 1;
    end
  end

  // ----------------------------------------
  // timing properties
  // ----------------------------------------

  // output strobe is the input strobe three edges late
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (settle_cnt >= `MUL_LATENCY) |-> (valid_o == $past(valid_i, `MUL_LATENCY)))
    else $error("valid_o does not follow valid_i by %0d edges", `MUL_LATENCY);

  // nothing leaves the pipeline during reset
  assert property (@(posedge clk_i) !arst_n_i |-> !valid_o)
    else $error("valid_o high while reset is active");

  // a presented product is fully defined
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o |-> !$isunknown(prod_o))
    else $error("prod_o has unknown bits while valid_o is high");

endmodule

bind mul16_top mul16_properties u_props (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .valid_i  (valid_i),
  .valid_o  (valid_o),
  .prod_o   (prod_o)
);

`default_nettype wire

// File: tb/mul16_tb.sv
// drives mul16_top on falling edges and checks every product and its arrival edge against a model

`default_nettype none

`include "mul_consts.svh"

module mul16_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import mul_pkg::*;

  // ----------------------------------------
  // run shape
  // ----------------------------------------

  localparam int PERIOD_NS   = 40;
  localparam int RST_CYCLES  = 2;
  localparam int IDLE_CYCLES = 10;
  localparam int N_CORNER    = 9;
  localparam int ISO_GAP     = 4;
  localparam int N_RAND      = 200;
  localparam int MAX_GAP     = 3;
  localparam int DRAIN       = `MUL_LATENCY + 2;
  localparam int MARGIN      = 20;
  localparam int SEED        = 11040;
  // every stimulus cycle, gaps counted at their longest
  localparam int STIM_CYCLES = RST_CYCLES + IDLE_CYCLES + N_CORNER + DRAIN + ISO_GAP + 1
                             + DRAIN + N_RAND + DRAIN + N_RAND * (1 + MAX_GAP) + DRAIN;
  localparam int WATCHDOG_NS = (STIM_CYCLES + `MUL_LATENCY + MARGIN) * PERIOD_NS;

  // dut ports
  logic     clk_i = 1'b0;
  logic     arst_n_i;
  logic     valid_i;
  operand_t a_i;
  operand_t b_i;
  logic     valid_o;
  product_t prod_o;

  // outstanding pairs, oldest first
  product_t    exp_prod_q [$];
  operand_t    exp_a_q [$];
  operand_t    exp_b_q [$];
  int unsigned exp_edge_q [$];

  int unsigned edge_cnt  = 0;
  int unsigned max_depth = 0;
  int unsigned errors    = 0;
  int unsigned checks    = 0;

  mul16_top uut (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .a_i      (a_i),
    .b_i      (b_i),
    .valid_o  (valid_o),
    .prod_o   (prod_o)
  );

  always #(PERIOD_NS / 2) clk_i = ~clk_i;

  // rising edge count, read only on falling edges
  always @(posedge clk_i) begin
    edge_cnt <= edge_cnt + 1;
  end

  // pairs in flight, queue is never touched on a rising edge
  always @(posedge clk_i) begin
    if (exp_prod_q.size() > max_depth) begin
      max_depth = exp_prod_q.size();
    end
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  // plain 16-row shift-and-add, no byte split
  function automatic product_t mul_ref(input operand_t a, input operand_t b);
    product_t acc;
    acc = '0;
    for (int r = 0; r < `MUL_OP_W; r++) begin
      if (b[r]) begin
        acc = acc + (product_t'(a) << r);
      end
    end
    return acc;
  endfunction

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------

  // one accepted pair, expected result due MUL_LATENCY edges later
  task automatic drive_pair(input operand_t a, input operand_t b);
    @(negedge clk_i);
    valid_i = 1'b1;
    a_i     = a;
    b_i     = b;
    exp_prod_q.push_back(mul_ref(a, b));
    exp_a_q.push_back(a);
    exp_b_q.push_back(b);
    exp_edge_q.push_back(edge_cnt + `MUL_LATENCY);
  endtask

  // strobe low, operand buses carry junk that must be ignored
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk_i);
      valid_i = 1'b0;
      a_i     = operand_t'($urandom);
      b_i     = operand_t'($urandom);
    end
  endtask

  // ----------------------------------------
  // comparison
  // ----------------------------------------

  always @(negedge clk_i) begin : compare
    product_t    exp_p;
    operand_t    exp_a;
    operand_t    exp_b;
    int unsigned exp_e;
    if (valid_o) begin
      if (!arst_n_i) begin
        errors++;
        $display("valid_o went high at %0t while reset was active", $time);
      end else if (exp_prod_q.size() == 0) begin
        errors++;
        $display("valid_o went high at %0t with no pair outstanding", $time);
      end else begin
        exp_p = exp_prod_q.pop_front();
        exp_a = exp_a_q.pop_front();
        exp_b = exp_b_q.pop_front();
        exp_e = exp_edge_q.pop_front();
        checks++;
        if (prod_o !== exp_p) begin
          errors++;
          $display("mismatch at %0t: %h * %h expected %h, got %h",
                   $time, exp_a, exp_b, exp_p, prod_o);
        end
        if (edge_cnt != exp_e) begin
          errors++;
          $display("result of %h * %h arrived at edge %0d instead of edge %0d",
                   exp_a, exp_b, edge_cnt, exp_e);
        end
      end
    end
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the run did not reach its end", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial begin
    operand_t    rnd;
    void'($urandom(SEED));
    arst_n_i  = 1'b0;
    valid_i   = 1'b0;
    a_i       = '0;
    b_i       = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // quiet pipeline after reset
    idle_cycles(IDLE_CYCLES);

    // corner operands
    rnd = operand_t'($urandom);
    drive_pair(16'h0000, rnd);
    drive_pair(rnd, 16'h0000);
    drive_pair(16'h0001, rnd);
    drive_pair(rnd, 16'h0001);
    drive_pair(16'hffff, 16'hffff);
    drive_pair(16'h00ff, 16'hff00);
    drive_pair(16'hff00, 16'h00ff);
    drive_pair(16'h0000, 16'h0000);
    drive_pair(16'h0001, 16'h0001);
    idle_cycles(DRAIN);

    // single isolated pair
    idle_cycles(ISO_GAP);
    drive_pair(16'h1234, 16'habcd);
    idle_cycles(DRAIN);

    // back to back, pipeline kept full
    max_depth = 0;
    for (int i = 0; i < N_RAND; i++) begin
      drive_pair(operand_t'($urandom), operand_t'($urandom));
    end
    idle_cycles(DRAIN);
    if (max_depth < `MUL_LATENCY) begin
      errors++;
      $display("only %0d pairs were in flight during the back-to-back stream", max_depth);
    end

    // random gaps between pairs
    for (int i = 0; i < N_RAND; i++) begin
      drive_pair(operand_t'($urandom), operand_t'($urandom));
      idle_cycles($urandom_range(MAX_GAP, 0));
    end
    idle_cycles(DRAIN);

    if (exp_prod_q.size() != 0) begin
      errors++;
      $display("%0d pairs never produced a result", exp_prod_q.size());
    end

    $display("%0d results checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/cr_adder.sv
// purely combinational ripple-carry adder; delay grows linearly with WIDTH, no pipelining

`default_nettype none

module cr_adder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] a_i,
  input  logic [WIDTH-1:0] b_i,
  input  logic             c_i,
  output logic [WIDTH-1:0] sum_o,
  output logic             c_o
);

  // carry chain, entry 0 is the carry in
  logic [WIDTH:0] carry;
  // per-bit propagate term
  logic [WIDTH-1:0] prop;

  assign carry[0] = c_i;

  // ----------------------------------------
  // full adder chain
  // ----------------------------------------

  for (genvar i = 0; i < WIDTH; i++) begin : g_fa
    // half sum of the two operand bits
    assign prop[i]      = a_i[i] ^ b_i[i];
    assign sum_o[i]     = prop[i] ^ carry[i];
    // generate, or propagate the incoming carry
    assign carry[i + 1] = (a_i[i] & b_i[i]) | (prop[i] & carry[i]);
  end

  // carry out of the top bit
  assign c_o = carry[WIDTH];

endmodule

`default_nettype wire

// File: verilog/lane_if.sv
// one lane's bundle; no clock inside, every stage samples it on the clock of the top level

`default_nettype none

interface lane_if;

  import mul_pkg::*;

  // ----------------------------------------
  // feeder to lane
  // ----------------------------------------

  // registered multiplicand byte
  half_t      a_half;
  // registered multiplier byte
  half_t      b_half;
  // operand pair present this cycle
  logic       valid;

  // ----------------------------------------
  // lane to drain
  // ----------------------------------------

  // registered 8x8 product
  half_prod_t prod;
  // product present this cycle
  logic       prod_valid;

  // input register stage drives the byte pair
  modport feeder (output a_half, output b_half, output valid);

  // lane consumes bytes, returns its product
  modport lane (input a_half, input b_half, input valid,
                output prod, output prod_valid);

  // summing stage only sees products
  modport drain (input prod, input prod_valid);

endinterface

`default_nettype wire

// File: verilog/mul16_operand_split.sv
// first pipeline stage; valid_i is a plain strobe with no back-pressure, operands taken only on it

`default_nettype none

`include "mul_consts.svh"

module mul16_operand_split (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               valid_i,
  input  mul_pkg::operand_t  a_i,
  input  mul_pkg::operand_t  b_i,
  lane_if.feeder             lanes_o [`MUL_LANES]
);

  import mul_pkg::*;

  // registered operand pair
  operand_t a_q;
  operand_t b_q;
  logic     valid_q;

  // ----------------------------------------
  // input register
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      a_q     <= '0;
      b_q     <= '0;
    end else begin
      valid_q <= valid_i;
      // hold the last pair while idle
      if (valid_i) begin
        a_q <= a_i;
        b_q <= b_i;
      end
    end
  end

  // ----------------------------------------
  // byte fan-out
  // ----------------------------------------

  // lane index bit 0 picks the a byte, bit 1 the b byte
  // lane 0 = aL*bL, 1 = aH*bL, 2 = aL*bH, 3 = aH*bH
  for (genvar i = 0; i < `MUL_LANES; i++) begin : g_fan
    assign lanes_o[i].a_half = (i % 2 == 1) ? a_q[`MUL_OP_W-1:`MUL_HALF_W]
                                            : a_q[`MUL_HALF_W-1:0];
    assign lanes_o[i].b_half = (i / 2 == 1) ? b_q[`MUL_OP_W-1:`MUL_HALF_W]
                                            : b_q[`MUL_HALF_W-1:0];
    // same strobe to every lane
    assign lanes_o[i].valid  = valid_q;
  end

endmodule

`default_nettype wire

// File: verilog/mul16_partial_sum.sv
// last pipeline stage; lane valids are assumed aligned, so lane 0's valid stands for all four

`default_nettype none

`include "mul_consts.svh"

module mul16_partial_sum (
  input  logic               clk_i,
  input  logic               arst_n_i,
  lane_if.drain              lanes_i [`MUL_LANES],
  output logic               valid_o,
  output mul_pkg::product_t  prod_o
);

  import mul_pkg::*;

  // aligned partial products
  product_t term_0;
  product_t term_1;
  product_t term_2;
  product_t term_3;

  // tree nodes
  product_t sum_lo;
  product_t sum_hi;
  product_t sum_all;

  // ----------------------------------------
  // alignment
  // ----------------------------------------

  // zero-extend, then shift to byte weight
  assign term_0 = product_t'(lanes_i[0].prod);
  // cross terms both sit one byte up
  assign term_1 = product_t'(lanes_i[1].prod) << `MUL_HALF_W;
  assign term_2 = product_t'(lanes_i[2].prod) << `MUL_HALF_W;
  // high by high sits two bytes up
  assign term_3 = product_t'(lanes_i[3].prod) << (2 * `MUL_HALF_W);

  // ----------------------------------------
  // adder tree
  // ----------------------------------------

  // level 1, lanes 0+1 and lanes 2+3
  cr_adder #(
    .WIDTH ($bits(product_t))
  ) u_add_lo (
    .a_i   (term_0),
    .b_i   (term_1),
    .c_i   (1'b0),
    .sum_o (sum_lo),
    .c_o   ()
  );

  cr_adder #(
    .WIDTH ($bits(product_t))
  ) u_add_hi (
    .a_i   (term_2),
    .b_i   (term_3),
    .c_i   (1'b0),
    .sum_o (sum_hi),
    .c_o   ()
  );

  // level 2, carry out is always zero for 16x16
  cr_adder #(
    .WIDTH ($bits(product_t))
  ) u_add_all (
    .a_i   (sum_lo),
    .b_i   (sum_hi),
    .c_i   (1'b0),
    .sum_o (sum_all),
    .c_o   ()
  );

  // ----------------------------------------
  // result register
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
      prod_o  <= '0;
    end else begin
      valid_o <= lanes_i[0].prod_valid;
      prod_o  <= sum_all;
    end
  end

endmodule

`default_nettype wire

// File: verilog/mul16_top.sv
// unsigned 16x16 multiply, three-cycle latency, one pair per clock, no stall or ready

`default_nettype none

`include "mul_consts.svh"

module mul16_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // operand pair, sampled when valid_i is high
  input  logic               valid_i,
  input  mul_pkg::operand_t  a_i,
  input  mul_pkg::operand_t  b_i,
  // one-cycle pulse per accepted pair
  output logic               valid_o,
  output mul_pkg::product_t  prod_o
);

  // ----------------------------------------
  // lane bundles
  // ----------------------------------------

  // one bundle per byte pair
  lane_if lanes [`MUL_LANES] ();

  // ----------------------------------------
  // stage 1, register and split
  // ----------------------------------------

  mul16_operand_split u_split (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .a_i      (a_i),
    .b_i      (b_i),
    .lanes_o  (lanes)
  );

  // ----------------------------------------
  // stage 2, partial products
  // ----------------------------------------

  // lane i multiplies the byte pair chosen by the split
  for (genvar i = 0; i < `MUL_LANES; i++) begin : g_lane
    mul8_lane #(
      .LANE (i)
    ) u_lane (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .lane_io  (lanes[i])
    );
  end

  // ----------------------------------------
  // stage 3, align and sum
  // ----------------------------------------

  mul16_partial_sum u_sum (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .lanes_i  (lanes),
    .valid_o  (valid_o),
    .prod_o   (prod_o)
  );

endmodule

`default_nettype wire

// File: verilog/mul8_lane.sv
// unsigned 8x8 lane, one register stage; LANE only labels the instance, arithmetic ignores it

`default_nettype none

`include "mul_consts.svh"

module mul8_lane #(
  parameter int LANE = 0
) (
  input  logic clk_i,
  input  logic arst_n_i,
  lane_if.lane lane_io
);

  import mul_pkg::*;

  // one shifted copy of a per bit of b
  half_prod_t rows [`MUL_HALF_W];
  // combinational sum of all rows
  half_prod_t row_sum;

  // ----------------------------------------
  // partial rows
  // ----------------------------------------

  // row r is a shifted left by r, gated by b[r]
  for (genvar r = 0; r < `MUL_HALF_W; r++) begin : g_row
    assign rows[r] = lane_io.b_half[r] ? (half_prod_t'(lane_io.a_half) << r) : '0;
  end

  // add the rows, result fits in 16 bits
  always_comb begin
    row_sum = '0;
    for (int k = 0; k < `MUL_HALF_W; k++) begin
      row_sum = row_sum + rows[k];
    end
  end

  // ----------------------------------------
  // output register
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lane_io.prod_valid <= 1'b0;
      lane_io.prod       <= '0;
    end else begin
      // valid follows the feeder strobe one edge later
      lane_io.prod_valid <= lane_io.valid;
      lane_io.prod       <= row_sum;
    end
  end

endmodule

`default_nettype wire

// File: verilog/mul_pkg.sv
// vector types only, sized from mul_consts.svh; operands and products are unsigned

`default_nettype none

`include "mul_consts.svh"

package mul_pkg;

  // ----------------------------------------
  // operand side
  // ----------------------------------------

  // one multiplicand or multiplier word
  typedef logic [`MUL_OP_W-1:0] operand_t;

  // one byte of an operand, fed to a lane
  typedef logic [`MUL_HALF_W-1:0] half_t;

  // ----------------------------------------
  // product side
  // ----------------------------------------

  // 8x8 lane product, never overflows 16 bits
  typedef logic [2*`MUL_HALF_W-1:0] half_prod_t;

  // full 32-bit product, two words
  typedef logic [2*`MUL_OP_W-1:0] product_t;

endpackage

`default_nettype wire
